// ==== logic/BranchUnit.sv ====
`timescale 1ns/1ps

module BranchUnit #(
    parameter int PcWidth = 32)                      // Instruction address width
(
    input  logic [PcWidth-1:0]         i_Pc,         // Address of this instruction
    input  logic [DecodePkg::XLen-1:0] i_Imm,        // Sign extended immediate
    input  logic [DecodePkg::XLen-1:0] i_DataA,      // rs1 value
    input  logic [DecodePkg::XLen-1:0] i_DataB,      // rs2 value
    input  DecodePkg::CtrlSignals      i_Ctrl,
    output logic [PcWidth-1:0]         o_JumpAddr,   // Redirect target
    output logic                       o_JumpEnable);

    import DecodePkg::*;

    logic               IsEq;
    logic               IsLt;
    logic               CondTrue;           // Branch condition holds
    logic [PcWidth-1:0] PcTarget;           // Branch and JAL target
    logic [XLen-1:0]    JalrSum;
    logic [PcWidth-1:0] JalrTarget;

    assign IsEq = (i_DataA == i_DataB);
    assign IsLt = ($signed(i_DataA) < $signed(i_DataB));

    always_comb begin
        case (i_Ctrl.BranchCond)
            BrEq:    CondTrue = IsEq;
            BrNe:    CondTrue = !IsEq;
            BrLt:    CondTrue = IsLt;
            BrGe:    CondTrue = !IsLt;
            default: CondTrue = 1'b0;
        endcase
    end

    // Offsets wrap within the address width
    assign PcTarget = i_Pc + i_Imm[PcWidth-1:0];

    assign JalrSum    = i_DataA + i_Imm;
    assign JalrTarget = {JalrSum[PcWidth-1:1], 1'b0};   // Bit 0 cleared

    assign o_JumpEnable = i_Ctrl.IsJal
                       || i_Ctrl.IsJalr
                       || (i_Ctrl.IsBranch && CondTrue);

    always_comb begin
        if (!o_JumpEnable) begin
            o_JumpAddr = '0;
        end else if (i_Ctrl.IsJalr) begin
            o_JumpAddr = JalrTarget;
        end else begin
            o_JumpAddr = PcTarget;
        end
    end

endmodule

// ==== logic/DecodePkg.sv ====
package DecodePkg;

    localparam int XLen = 32;                    // RV32I data width

    // Major opcodes of the supported subset
    localparam logic [6:0] OpcOp     = 7'b0110011;   // Register ALU ops
    localparam logic [6:0] OpcOpImm  = 7'b0010011;   // Immediate ALU ops
    localparam logic [6:0] OpcLoad   = 7'b0000011;   // Loads
    localparam logic [6:0] OpcStore  = 7'b0100011;   // Stores
    localparam logic [6:0] OpcBranch = 7'b1100011;   // Conditional branches
    localparam logic [6:0] OpcJal    = 7'b1101111;   // Jump and link
    localparam logic [6:0] OpcJalr   = 7'b1100111;   // Jump and link register

    localparam logic [2:0] Funct3Word = 3'b010;      // LW and SW width

    // Operation requested from the execute stage ALU
    typedef enum logic [3:0] {
        AluAdd = 4'd0,                           // Reset value
        AluSub = 4'd1,
        AluAnd = 4'd2,
        AluOr  = 4'd3,
        AluXor = 4'd4,
        AluSlt = 4'd5,                           // Signed set less than
        AluSll = 4'd6,
        AluSrl = 4'd7
    } AluOp;

    // Register writeback source
    typedef enum logic [1:0] {
        WbAlu  = 2'd0,                           // ALU result
        WbMem  = 2'd1,                           // Load data
        WbLink = 2'd2                            // Return address
    } WbSel;

    // Branch condition, same encoding as the branch funct3
    typedef enum logic [2:0] {
        BrEq = 3'b000,
        BrNe = 3'b001,
        BrLt = 3'b100,
        BrGe = 3'b101
    } BranchKind;

    typedef struct packed {
        AluOp       AluControl;                  // ALU operation
        logic       AluSrcB;                     // 1 selects the immediate
        logic       RegWrEnable;                 // Writes rd
        logic       MemWrEnable;                 // Writes memory
        WbSel       DataToRegSel;                // Writeback source
        logic       IsBranch;
        logic       IsJal;
        logic       IsJalr;
        BranchKind  BranchCond;                  // Only meaningful with IsBranch
    } CtrlSignals;

    typedef struct packed {
        logic [XLen-1:0] DataA;                  // rs1 read data
        logic [XLen-1:0] DataB;                  // rs2 read data
        logic [4:0]      Rs1;
        logic [4:0]      Rs2;
        logic [4:0]      Rd;
        logic [XLen-1:0] Imm;                    // Sign extended immediate
        AluOp            AluControl;
        logic            AluSrcB;
        logic            RegWrEnable;
        logic            MemWrEnable;
        WbSel            DataToRegSel;
        logic [XLen-1:0] PcPlus4;                // Link value
    } IdExBundle;

endpackage

// ==== logic/InstDecoder.sv ====
`timescale 1ns/1ps

module InstDecoder (
    input  logic [31:0]                i_Inst,   // Instruction word
    output logic [4:0]                 o_Rs1,    // Source register 1
    output logic [4:0]                 o_Rs2,    // Source register 2
    output logic [4:0]                 o_Rd,     // Destination register
    output logic [DecodePkg::XLen-1:0] o_Imm);   // Sign extended immediate

    import DecodePkg::*;

    logic [6:0]      Opcode;
    logic [XLen-1:0] ImmI;
    logic [XLen-1:0] ImmS;
    logic [XLen-1:0] ImmB;
    logic [XLen-1:0] ImmJ;

    assign Opcode = i_Inst[6:0];

    // Register fields sit at fixed positions in every format
    assign o_Rs1 = i_Inst[19:15];
    assign o_Rs2 = i_Inst[24:20];
    assign o_Rd  = i_Inst[11:7];

    // I format, used by OP-IMM, loads and JALR
    assign ImmI = {{20{i_Inst[31]}}, i_Inst[31:20]};

    // S format splits the offset around rd
    assign ImmS = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};

    // B format, offset in multiples of two
    assign ImmB = {{19{i_Inst[31]}},
                   i_Inst[31],
                   i_Inst[7],
                   i_Inst[30:25],
                   i_Inst[11:8],
                   1'b0};

    // J format, 21 bit offset
    assign ImmJ = {{11{i_Inst[31]}},
                   i_Inst[31],
                   i_Inst[19:12],
                   i_Inst[20],
                   i_Inst[30:21],
                   1'b0};

    always_comb begin
        case (Opcode)
            OpcOpImm,
            OpcLoad,
            OpcJalr:   o_Imm = ImmI;
            OpcStore:  o_Imm = ImmS;
            OpcBranch: o_Imm = ImmB;
            OpcJal:    o_Imm = ImmJ;
            default:   o_Imm = '0;               // R-type and unknown opcodes
        endcase
    end

endmodule

// ==== logic/MainController.sv ====
`timescale 1ns/1ps

module MainController (
    input  logic [31:0]           i_Inst,   // Instruction word
    output DecodePkg::CtrlSignals o_Ctrl);  // Datapath control

    import DecodePkg::*;

    logic [6:0] Opcode;
    logic [2:0] Funct3;
    logic       Funct7b5;
    AluOp       AluSel;                     // ALU op from funct3
    logic       AluOk;                      // funct3 is in the subset

    assign Opcode   = i_Inst[6:0];
    assign Funct3   = i_Inst[14:12];
    assign Funct7b5 = i_Inst[30];

    // Shared funct3 map for OP and OP-IMM
    function automatic logic AluFromFunct3(
        input  logic [2:0] f3,
        input  logic       f7b5,
        input  logic       isReg,
        output AluOp       op);
        AluFromFunct3 = 1'b1;
        op            = AluAdd;
        case (f3)
            3'b000: op = (isReg && f7b5) ? AluSub : AluAdd;
            3'b001: op = AluSll;
            3'b010: op = AluSlt;
            3'b100: op = AluXor;
            3'b101: begin
                op            = AluSrl;
                AluFromFunct3 = !f7b5;      // Arithmetic shift unsupported
            end
            3'b110: op = AluOr;
            3'b111: op = AluAnd;
            default: AluFromFunct3 = 1'b0;  // SLTU and SLTIU
        endcase
    endfunction

    always_comb begin
        AluOk  = AluFromFunct3(Funct3, Funct7b5, Opcode == OpcOp, AluSel);
        o_Ctrl = '0;                        // No-operation by default
        case (Opcode)
            OpcOp: begin
                if (AluOk) begin
                    o_Ctrl.AluControl  = AluSel;
                    o_Ctrl.RegWrEnable = 1'b1;
                end
            end
            OpcOpImm: begin
                if (AluOk) begin
                    o_Ctrl.AluControl  = AluSel;
                    o_Ctrl.AluSrcB     = 1'b1;
                    o_Ctrl.RegWrEnable = 1'b1;
                end
            end
            OpcLoad: begin
                if (Funct3 == Funct3Word) begin
                    o_Ctrl.AluSrcB      = 1'b1;   // Base plus offset
                    o_Ctrl.RegWrEnable  = 1'b1;
                    o_Ctrl.DataToRegSel = WbMem;
                end
            end
            OpcStore: begin
                if (Funct3 == Funct3Word) begin
                    o_Ctrl.AluSrcB     = 1'b1;
                    o_Ctrl.MemWrEnable = 1'b1;
                end
            end
            OpcBranch: begin
                if (Funct3 inside {BrEq, BrNe, BrLt, BrGe}) begin
                    o_Ctrl.AluControl = AluSub;
                    o_Ctrl.IsBranch   = 1'b1;
                    o_Ctrl.BranchCond = BranchKind'(Funct3);
                end
            end
            OpcJal: begin
                o_Ctrl.RegWrEnable  = 1'b1;
                o_Ctrl.DataToRegSel = WbLink;
                o_Ctrl.IsJal        = 1'b1;
            end
            OpcJalr: begin
                if (Funct3 == 3'b000) begin
                    o_Ctrl.AluSrcB      = 1'b1;
                    o_Ctrl.RegWrEnable  = 1'b1;
                    o_Ctrl.DataToRegSel = WbLink;
                    o_Ctrl.IsJalr       = 1'b1;
                end
            end
            default: o_Ctrl = '0;           // Outside the subset
        endcase
    end

endmodule

// ==== logic/RegisterFile.sv ====
`timescale 1ns/1ps

module RegisterFile (
    input  logic                       i_Clock,
    input  logic                       i_rst,       // Clears every register
    input  logic                       i_WrEnable,  // Write strobe
    input  logic [4:0]                 i_WrAddr,
    input  logic [DecodePkg::XLen-1:0] i_WrData,
    input  logic [4:0]                 i_RdAddrA,
    input  logic [4:0]                 i_RdAddrB,
    output logic [DecodePkg::XLen-1:0] o_RdDataA,
    output logic [DecodePkg::XLen-1:0] o_RdDataB);

    import DecodePkg::*;

    logic [XLen-1:0] Regs [32];
    logic            WrValid;               // Write to a real register

    assign WrValid = i_WrEnable && (i_WrAddr != 5'd0);

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                Regs[i] <= '0;
            end
        end else if (WrValid) begin
            Regs[i_WrAddr] <= i_WrData;
        end
    end

    // x0 reads zero and a pending write is forwarded
    function automatic logic [XLen-1:0] ReadPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            ReadPort = '0;
        end else if (WrValid && (addr == i_WrAddr)) begin
            ReadPort = i_WrData;
        end else begin
            ReadPort = Regs[addr];
        end
    endfunction

    always_comb begin
        o_RdDataA = ReadPort(i_RdAddrA);
        o_RdDataB = ReadPort(i_RdAddrB);
    end

endmodule

// ==== logic/StageID.sv ====
`timescale 1ns/1ps

module StageID #(
    parameter int PcWidth = 32)                        // Instruction address width
(
    input  logic                       i_Clock,
    input  logic                       i_rst,          // Synchronous reset
    input  logic [31:0]                i_Inst,         // Instruction from fetch
    input  logic [PcWidth-1:0]         i_Pc,           // Address of i_Inst
    input  logic                       i_RegWrEnable,  // Writeback strobe
    input  logic [4:0]                 i_RegWrAddr,    // Writeback register
    input  logic [DecodePkg::XLen-1:0] i_RegWrData,    // Writeback value
    output DecodePkg::IdExBundle       o_IdEx,         // To execute stage
    output logic [PcWidth-1:0]         o_JumpAddr,     // Redirect target
    output logic                       o_JumpEnable);  // Redirect strobe

    import DecodePkg::*;

    logic [4:0]         DecRs1;
    logic [4:0]         DecRs2;
    logic [4:0]         DecRd;
    logic [XLen-1:0]    DecImm;
    CtrlSignals         Ctrl;
    logic [XLen-1:0]    RfDataA;
    logic [XLen-1:0]    RfDataB;
    logic [PcWidth-1:0] PcPlus4;
    IdExBundle          NextIdEx;

    InstDecoder u_InstDecoder (
        .i_Inst (i_Inst),
        .o_Rs1  (DecRs1),
        .o_Rs2  (DecRs2),
        .o_Rd   (DecRd),
        .o_Imm  (DecImm));

    MainController u_MainController (
        .i_Inst (i_Inst),
        .o_Ctrl (Ctrl));

    RegisterFile u_RegisterFile (
        .i_Clock    (i_Clock),
        .i_rst      (i_rst),
        .i_WrEnable (i_RegWrEnable),
        .i_WrAddr   (i_RegWrAddr),
        .i_WrData   (i_RegWrData),
        .i_RdAddrA  (DecRs1),
        .i_RdAddrB  (DecRs2),
        .o_RdDataA  (RfDataA),
        .o_RdDataB  (RfDataB));

    BranchUnit #(
        .PcWidth (PcWidth))
    u_BranchUnit (
        .i_Pc         (i_Pc),
        .i_Imm        (DecImm),
        .i_DataA      (RfDataA),
        .i_DataB      (RfDataB),
        .i_Ctrl       (Ctrl),
        .o_JumpAddr   (o_JumpAddr),
        .o_JumpEnable (o_JumpEnable));

    assign PcPlus4 = i_Pc + PcWidth'(4);

    always_comb begin
        NextIdEx              = '0;
        NextIdEx.DataA        = RfDataA;
        NextIdEx.DataB        = RfDataB;
        NextIdEx.Rs1          = DecRs1;
        NextIdEx.Rs2          = DecRs2;
        NextIdEx.Rd           = DecRd;
        NextIdEx.Imm          = DecImm;
        NextIdEx.AluControl   = Ctrl.AluControl;
        NextIdEx.AluSrcB      = Ctrl.AluSrcB;
        NextIdEx.RegWrEnable  = Ctrl.RegWrEnable;
        NextIdEx.MemWrEnable  = Ctrl.MemWrEnable;
        NextIdEx.DataToRegSel = Ctrl.DataToRegSel;
        NextIdEx.PcPlus4      = XLen'(PcPlus4);   // Zero extended link
    end

    // ID/EX pipeline register
    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            o_IdEx <= '0;                   // Enables low and AluAdd
        end else begin
            o_IdEx <= NextIdEx;
        end
    end

endmodule

// ==== project.f ====
logic/DecodePkg.sv
logic/InstDecoder.sv
logic/MainController.sv
logic/RegisterFile.sv
logic/BranchUnit.sv
logic/StageID.sv
sim/tb_StageID.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_StageID -f project.f

out=$(./obj_dir/Vtb_StageID)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
    exit 0
else
    exit 1
fi

// ==== sim/tb_StageID.sv ====
`timescale 1ns/1ps

module tb_StageID;

    import DecodePkg::*;

    localparam int PcWidth     = 32;
    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 16;

    // Instruction word with the offset it was encoded from
    typedef struct packed {
        logic [31:0] Word;
        logic [31:0] Imm;                   // Sign extended offset
    } EncInst;

    // One row of the stimulus table
    typedef struct packed {
        logic [31:0] Inst;
        logic [31:0] Pc;
        logic        WrEn;                  // Writeback port setting
        logic [4:0]  WrAddr;
        logic [31:0] WrData;
        logic        ExpJmpEn;
        logic [31:0] ExpJmpAddr;
        IdExBundle   ExpIdEx;
    } TestEntry;

    logic               i_Clock;
    logic               i_rst;
    logic [31:0]        i_Inst;
    logic [PcWidth-1:0] i_Pc;
    logic               i_RegWrEnable;
    logic [4:0]         i_RegWrAddr;
    logic [31:0]        i_RegWrData;
    IdExBundle          o_IdEx;
    logic [PcWidth-1:0] o_JumpAddr;
    logic               o_JumpEnable;

    TestEntry    Table[$];
    logic [31:0] Shadow [32];               // Reference register state
    logic [31:0] CurPc;
    logic        TableReady = 1'b0;
    integer      Seed = 32'h71fc_289e;
    int          CheckErrors = 0;
    int          PassCount = 0;
    int          FailCount = 0;

    StageID #(
        .PcWidth (PcWidth))
    u_StageID (
        .i_Clock       (i_Clock),
        .i_rst         (i_rst),
        .i_Inst        (i_Inst),
        .i_Pc          (i_Pc),
        .i_RegWrEnable (i_RegWrEnable),
        .i_RegWrAddr   (i_RegWrAddr),
        .i_RegWrData   (i_RegWrData),
        .o_IdEx        (o_IdEx),
        .o_JumpAddr    (o_JumpAddr),
        .o_JumpEnable  (o_JumpEnable));

    always #(ClkPeriod/2) i_Clock = ~i_Clock;

    // R-type carries no immediate
    function automatic EncInst encR(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OpcOp, 32'd0};
    endfunction

    function automatic EncInst encI(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc, {20{imm[11]}}, imm};
    endfunction

    function automatic EncInst encS(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, Funct3Word, imm[4:0], OpcStore, {20{imm[11]}}, imm};
    endfunction

    // Branch offsets are multiples of two
    function automatic EncInst encB(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpcBranch,
                {19{imm[12]}}, imm[12:1], 1'b0};
    endfunction

    function automatic EncInst encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpcJal,
                {11{imm[20]}}, imm[20:1], 1'b0};
    endfunction

    function automatic logic [31:0] shadowRead(input logic [4:0] addr, input logic wrEn,
        input logic [4:0] wrAddr, input logic [31:0] wrData);
        if (addr == 5'd0) return 32'd0;
        if (wrEn && (addr == wrAddr)) return wrData;   // Same-cycle write
        return Shadow[addr];
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    // Builds one row from the reference model, then applies its write
    task automatic addEntry(input EncInst enc, input logic wrEn, input logic [4:0] wrAddr,
        input logic [31:0] wrData, input AluOp aluOp, input logic srcB, input logic regWr,
        input logic memWr, input WbSel wb);
        TestEntry    e;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        e    = '0;
        inst = enc.Word;
        imm  = enc.Imm;
        a    = shadowRead(inst[19:15], wrEn, wrAddr, wrData);
        b    = shadowRead(inst[24:20], wrEn, wrAddr, wrData);
        e.Inst   = inst;
        e.Pc     = CurPc;
        e.WrEn   = wrEn;
        e.WrAddr = wrAddr;
        e.WrData = wrData;
        if (inst[6:0] == OpcJal || (inst[6:0] == OpcBranch && branchTaken(inst[14:12], a, b)))
        begin
            e.ExpJmpEn   = 1'b1;
            e.ExpJmpAddr = CurPc + imm;
        end else if (inst[6:0] == OpcJalr && inst[14:12] == 3'b000) begin
            e.ExpJmpEn   = 1'b1;
            e.ExpJmpAddr = (a + imm) & ~32'd1;   // Bit 0 cleared
        end
        e.ExpIdEx.DataA        = a;
        e.ExpIdEx.DataB        = b;
        e.ExpIdEx.Rs1          = inst[19:15];
        e.ExpIdEx.Rs2          = inst[24:20];
        e.ExpIdEx.Rd           = inst[11:7];
        e.ExpIdEx.Imm          = imm;
        e.ExpIdEx.AluControl   = aluOp;
        e.ExpIdEx.AluSrcB      = srcB;
        e.ExpIdEx.RegWrEnable  = regWr;
        e.ExpIdEx.MemWrEnable  = memWr;
        e.ExpIdEx.DataToRegSel = wb;
        e.ExpIdEx.PcPlus4      = CurPc + 32'd4;
        Table.push_back(e);
        if (wrEn && wrAddr != 5'd0) Shadow[wrAddr] = wrData;
        CurPc = CurPc + 32'd4;
    endtask

    task automatic buildTable();
        logic [31:0] r;
        for (int i = 0; i < 32; i++) Shadow[i] = 32'd0;
        CurPc = 32'h0000_1000;
        for (int i = 0; i < 16; i++)             // All registers read zero after reset
            addEntry(encR(7'h00, 5'(2*i+1), 5'(2*i), 3'b110, 5'(i)), 0, 0, 0,
                     AluOr, 0, 1, 0, WbAlu);
        for (int k = 1; k < 32; k++) begin      // Write with bypass on port A
            r = $random(Seed);
            addEntry(encR(7'h00, 5'(k-1), 5'(k), 3'b000, 5'(k)), 1, 5'(k), r,
                     AluAdd, 0, 1, 0, WbAlu);
        end
        for (int i = 0; i < 32; i++)             // Readback through both ports
            addEntry(encR(7'h20, 5'(31-i), 5'(i), 3'b000, 5'd3), 0, 0, 0,
                     AluSub, 0, 1, 0, WbAlu);
        r = $random(Seed);
        addEntry(encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd1), 1, 5'd0, r, AluAdd, 0, 1, 0, WbAlu);
        addEntry(encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd1), 0, 0, 0, AluAdd, 0, 1, 0, WbAlu);
        // Register ALU ops also load the branch operands
        addEntry(encR(7'h00, 5'd6, 5'd5, 3'b000, 5'd10), 1, 5'd5, 32'hFFFF_FFFB,
                 AluAdd, 0, 1, 0, WbAlu);
        addEntry(encR(7'h20, 5'd6, 5'd5, 3'b000, 5'd10), 1, 5'd6, 32'd3, AluSub, 0, 1, 0, WbAlu);
        addEntry(encR(7'h00, 5'd6, 5'd5, 3'b111, 5'd10), 1, 5'd7, 32'd3, AluAnd, 0, 1, 0, WbAlu);
        addEntry(encR(7'h00, 5'd6, 5'd5, 3'b110, 5'd11), 0, 0, 0, AluOr, 0, 1, 0, WbAlu);
        addEntry(encR(7'h00, 5'd6, 5'd5, 3'b100, 5'd12), 0, 0, 0, AluXor, 0, 1, 0, WbAlu);
        addEntry(encR(7'h00, 5'd6, 5'd5, 3'b010, 5'd13), 0, 0, 0, AluSlt, 0, 1, 0, WbAlu);
        addEntry(encR(7'h00, 5'd6, 5'd5, 3'b001, 5'd14), 0, 0, 0, AluSll, 0, 1, 0, WbAlu);
        addEntry(encR(7'h00, 5'd6, 5'd5, 3'b101, 5'd15), 0, 0, 0, AluSrl, 0, 1, 0, WbAlu);
        addEntry(encI(12'h7FF, 5'd5, 3'b000, 5'd9, OpcOpImm), 0, 0, 0, AluAdd, 1, 1, 0, WbAlu);
        addEntry(encI(12'h800, 5'd6, 3'b000, 5'd9, OpcOpImm), 0, 0, 0, AluAdd, 1, 1, 0, WbAlu);
        addEntry(encI(12'hF0F, 5'd7, 3'b111, 5'd9, OpcOpImm), 0, 0, 0, AluAnd, 1, 1, 0, WbAlu);
        addEntry(encI(12'h123, 5'd5, 3'b110, 5'd9, OpcOpImm), 0, 0, 0, AluOr, 1, 1, 0, WbAlu);
        addEntry(encI(12'hFFF, 5'd5, 3'b100, 5'd9, OpcOpImm), 0, 0, 0, AluXor, 1, 1, 0, WbAlu);
        addEntry(encI(12'hFFD, 5'd5, 3'b010, 5'd9, OpcOpImm), 0, 0, 0, AluSlt, 1, 1, 0, WbAlu);
        addEntry(encI(12'h005, 5'd6, 3'b001, 5'd9, OpcOpImm), 0, 0, 0, AluSll, 1, 1, 0, WbAlu);
        addEntry(encI(12'h01F, 5'd6, 3'b101, 5'd9, OpcOpImm), 0, 0, 0, AluSrl, 1, 1, 0, WbAlu);
        // x5 = -5, x6 = 3, x7 = 3
        addEntry(encB(13'h0010, 5'd7, 5'd6, 3'b000), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encB(13'h0010, 5'd6, 5'd5, 3'b000), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encB(13'h1FE0, 5'd6, 5'd5, 3'b001), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encB(13'h1FE0, 5'd7, 5'd6, 3'b001), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encB(13'h0FFE, 5'd6, 5'd5, 3'b100), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encB(13'h0FFE, 5'd5, 5'd6, 3'b100), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encB(13'h1000, 5'd5, 5'd6, 3'b101), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encB(13'h1000, 5'd6, 5'd5, 3'b101), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encB(13'h0008, 5'd7, 5'd6, 3'b101), 0, 0, 0, AluSub, 0, 0, 0, WbAlu);
        addEntry(encI(12'h010, 5'd5, 3'b010, 5'd8, OpcLoad), 0, 0, 0, AluAdd, 1, 1, 0, WbMem);
        addEntry(encS(12'hFF8, 5'd6, 5'd5), 0, 0, 0, AluAdd, 1, 0, 1, WbAlu);
        addEntry(encJ(21'h1FFFF0, 5'd1), 0, 0, 0, AluAdd, 0, 1, 0, WbLink);
        addEntry(encJ(21'h000800, 5'd1), 0, 0, 0, AluAdd, 0, 1, 0, WbLink);
        addEntry(encI(12'h00E, 5'd5, 3'b000, 5'd1, OpcJalr), 0, 0, 0, AluAdd, 1, 1, 0, WbLink);
        addEntry(encI(12'hFFF, 5'd6, 3'b000, 5'd1, OpcJalr), 0, 0, 0, AluAdd, 1, 1, 0, WbLink);
        addEntry({32'h0000_707F, 32'd0}, 0, 0, 0, AluAdd, 0, 0, 0, WbAlu);   // Unknown opcode
        addEntry({32'h0000_0000, 32'd0}, 0, 0, 0, AluAdd, 0, 0, 0, WbAlu);
    endtask

    task automatic checkReset();
        if (o_IdEx !== '0) begin
            $display("Mismatch at %0t: bundle after reset is %h", $time, o_IdEx);
            CheckErrors++;
        end
        if (o_JumpEnable !== 1'b0) begin
            $display("Mismatch at %0t: redirect active after reset", $time);
            CheckErrors++;
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic runEntry(input int idx, input TestEntry e);
        int errsBefore;
        errsBefore    = CheckErrors;
        i_Inst        = e.Inst;
        i_Pc          = e.Pc;
        i_RegWrEnable = e.WrEn;
        i_RegWrAddr   = e.WrAddr;
        i_RegWrData   = e.WrData;
        #(ClkPeriod/2 - 2);                     // Just before the rising edge
        if (o_JumpEnable !== e.ExpJmpEn || o_JumpAddr !== e.ExpJmpAddr) begin
            $display("Mismatch at %0t: test %0d redirect expected %b %h, got %b %h", $time,
                     idx, e.ExpJmpEn, e.ExpJmpAddr, o_JumpEnable, o_JumpAddr);
            CheckErrors++;
        end
        @(posedge i_Clock);
        #1;
        if (o_IdEx !== e.ExpIdEx) begin
            $display("Mismatch at %0t: test %0d bundle expected %h, got %h", $time,
                     idx, e.ExpIdEx, o_IdEx);
            CheckErrors++;
        end
        if (CheckErrors == errsBefore) PassCount++;
        else FailCount++;
        $display("Test %0d inst %h pc %h: %s", idx, e.Inst, e.Pc,
                 (CheckErrors == errsBefore) ? "ok" : "failed");
        @(negedge i_Clock);
    endtask

    initial begin
        int errsBefore;
        i_Clock       = 1'b0;
        i_rst         = 1'b1;
        i_Inst        = '0;
        i_Pc          = '0;
        i_RegWrEnable = 1'b0;
        i_RegWrAddr   = '0;
        i_RegWrData   = '0;
        buildTable();
        TableReady = 1'b1;
        repeat (ResetCycles) @(posedge i_Clock);
        @(negedge i_Clock);
        i_rst = 1'b0;
        errsBefore = CheckErrors;
        checkReset();
        if (CheckErrors == errsBefore) PassCount++;
        else FailCount++;
        $display("Test reset: %s", (CheckErrors == errsBefore) ? "ok" : "failed");
        for (int i = 0; i < Table.size(); i++) runEntry(i, Table[i]);
        $display("Tests passed: %0d, failed: %0d", PassCount, FailCount);
        if (FailCount == 0 && CheckErrors == 0) $display("RESULT: PASS");
        else $display("RESULT: FAIL");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        int limit;
        wait (TableReady);
        limit = Table.size() * 4 + ResetCycles + 40;
        repeat (limit) @(posedge i_Clock);
        $display("Timeout: run did not finish within %0d clock cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
